//--- hw/sys_bus_pkg.sv
////////////////////////////////////////////////////////////
// shared widths, address map and bus structs for the
// system bus subsystem, referenced by scoped names
////////////////////////////////////////////////////////////

package sys_bus_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned ADR_W   = 32;       // address width
  localparam int unsigned DAT_W   = 32;       // data width
  localparam int unsigned SEL_W   = DAT_W/8;  // byte select width
  localparam int unsigned DEV_LSB = 28;       // lowest device select bit

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////

  // device select lives in adr[31:28]
  localparam logic [ADR_W-1:0] RAM_BASE  = 32'h0000_0000;
  localparam logic [ADR_W-1:0] GPIO_BASE = 32'h1000_0000;
  localparam logic [ADR_W-1:0] TXQ_BASE  = 32'h2000_0000;

  // register offsets inside a device
  localparam logic [ADR_W-1:0] GPIO_OUT_OFS = 32'h0;  // output register
  localparam logic [ADR_W-1:0] GPIO_IN_OFS  = 32'h4;  // synced input
  localparam logic [ADR_W-1:0] TXQ_DATA_OFS = 32'h0;  // push byte
  localparam logic [ADR_W-1:0] TXQ_STAT_OFS = 32'h4;  // level and full

  // decoded target, DEV_NONE for anything unmapped
  typedef enum logic [1:0] {
    DEV_RAM  = 2'd0,
    DEV_GPIO = 2'd1,
    DEV_TXQ  = 2'd2,
    DEV_NONE = 2'd3
  } sys_dev_e;

  // master to device, 70 bits
  typedef struct packed {
    logic             req;  // request
    logic             wen;  // write enable
    logic [ADR_W-1:0] adr;  // byte address
    logic [SEL_W-1:0] sel;  // byte select
    logic [DAT_W-1:0] wdt;  // write data
  } sys_req_t;

  // device to master, 33 bits
  typedef struct packed {
    logic [DAT_W-1:0] rdt;  // read data, cycle after transfer
    logic             ack;  // acknowledge, same cycle
  } sys_rsp_t;

endpackage

//--- hw/sys_bus_dec.sv
////////////////////////////////////////////////////////////
// address decoder, one master port to RAM, GPIO and TXQ
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_bus_dec (
  input  logic                  clk,
  input  logic                  rst,
  input  sys_bus_pkg::sys_req_t bus_req,   // from master
  output sys_bus_pkg::sys_rsp_t bus_rsp,   // to master
  output sys_bus_pkg::sys_req_t ram_req,
  output sys_bus_pkg::sys_req_t gpio_req,
  output sys_bus_pkg::sys_req_t txq_req,
  input  sys_bus_pkg::sys_rsp_t ram_rsp,
  input  sys_bus_pkg::sys_rsp_t gpio_rsp,
  input  sys_bus_pkg::sys_rsp_t txq_rsp
);

  localparam int unsigned MSB = sys_bus_pkg::ADR_W - 1;
  localparam int unsigned LSB = sys_bus_pkg::DEV_LSB;

  sys_bus_pkg::sys_dev_e dev;    // decode of current request
  sys_bus_pkg::sys_dev_e dev_q;  // decode at last transfer

  ////////////////////////////////////////////////////////////
  // forward path
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (bus_req.adr[MSB:LSB] == sys_bus_pkg::RAM_BASE[MSB:LSB])       dev = sys_bus_pkg::DEV_RAM;
    else if (bus_req.adr[MSB:LSB] == sys_bus_pkg::GPIO_BASE[MSB:LSB]) dev = sys_bus_pkg::DEV_GPIO;
    else if (bus_req.adr[MSB:LSB] == sys_bus_pkg::TXQ_BASE[MSB:LSB])  dev = sys_bus_pkg::DEV_TXQ;
    else                                                              dev = sys_bus_pkg::DEV_NONE;
  end

  // all fields fan out, only req is gated
  always_comb begin
    ram_req      = bus_req;
    gpio_req     = bus_req;
    txq_req      = bus_req;
    ram_req.req  = bus_req.req & (dev == sys_bus_pkg::DEV_RAM);
    gpio_req.req = bus_req.req & (dev == sys_bus_pkg::DEV_GPIO);
    txq_req.req  = bus_req.req & (dev == sys_bus_pkg::DEV_TXQ);
  end

  ////////////////////////////////////////////////////////////
  // backward path
  ////////////////////////////////////////////////////////////

  // ack follows the current decode
  always_comb begin
    case (dev)
      sys_bus_pkg::DEV_RAM:  bus_rsp.ack = ram_rsp.ack;
      sys_bus_pkg::DEV_GPIO: bus_rsp.ack = gpio_rsp.ack;
      sys_bus_pkg::DEV_TXQ:  bus_rsp.ack = txq_rsp.ack;
      default:               bus_rsp.ack = 1'b1;  // unmapped, never hang
    endcase
  end

  // read data follows the decode stored at the transfer
  always_comb begin
    case (dev_q)
      sys_bus_pkg::DEV_RAM:  bus_rsp.rdt = ram_rsp.rdt;
      sys_bus_pkg::DEV_GPIO: bus_rsp.rdt = gpio_rsp.rdt;
      sys_bus_pkg::DEV_TXQ:  bus_rsp.rdt = txq_rsp.rdt;
      default:               bus_rsp.rdt = '0;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      dev_q <= sys_bus_pkg::DEV_NONE;
    end else if (bus_req.req & bus_rsp.ack) begin
      dev_q <= dev;  // keeps overlapped reads on the right device
    end
  end

endmodule

//--- hw/sys_ram.sv
////////////////////////////////////////////////////////////
// word RAM on the system bus, byte-select writes and
// registered read data one cycle after the transfer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_ram #(
  parameter int unsigned RAM_DEPTH = 256  // words
) (
  input  logic                  clk,
  input  logic                  rst,
  input  sys_bus_pkg::sys_req_t req,
  output sys_bus_pkg::sys_rsp_t rsp
);

  localparam int unsigned IDX_W = $clog2(RAM_DEPTH);

  logic [sys_bus_pkg::DAT_W-1:0] mem [RAM_DEPTH];
  logic [sys_bus_pkg::DAT_W-1:0] rdt_q;
  logic [IDX_W-1:0]              idx;   // word index, wraps
  logic                          wr;
  logic                          rd;

  // byte offset dropped
  assign idx = req.adr[IDX_W+1:2];

  // always ready, so a request is a transfer
  assign wr = req.req &  req.wen;
  assign rd = req.req & ~req.wen;

  ////////////////////////////////////////////////////////////
  // array
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr) begin
      for (int b = 0; b < sys_bus_pkg::SEL_W; b++) begin
        if (req.sel[b]) mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];  // lane b
      end
    end
  end

  // read word held until the next read
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rdt_q <= '0;
    end else if (rd) begin
      rdt_q <= mem[idx];
    end
  end

  assign rsp = '{rdt: rdt_q, ack: 1'b1};

endmodule

//--- hw/sys_gpio.sv
////////////////////////////////////////////////////////////
// GPIO block, byte-writable output register and a
// synchronized input port, both readable on the bus
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_gpio (
  input  logic                          clk,
  input  logic                          rst,
  input  sys_bus_pkg::sys_req_t         req,
  output sys_bus_pkg::sys_rsp_t         rsp,
  input  logic [sys_bus_pkg::DAT_W-1:0] gpio_in,   // async pins
  output logic [sys_bus_pkg::DAT_W-1:0] gpio_out
);

  logic [sys_bus_pkg::DAT_W-1:0] in_meta;  // first sync stage
  logic [sys_bus_pkg::DAT_W-1:0] in_sync;  // IN register value
  logic [sys_bus_pkg::DAT_W-1:0] rdt_q;
  logic                          sel_in;   // adr[2] picks IN
  logic                          wr_out;
  logic                          rd;

  assign sel_in = (req.adr[2] == sys_bus_pkg::GPIO_IN_OFS[2]);
  assign wr_out = req.req & req.wen & (req.adr[2] == sys_bus_pkg::GPIO_OUT_OFS[2]);
  assign rd     = req.req & ~req.wen;

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      gpio_out <= '0;
    end else if (wr_out) begin
      for (int b = 0; b < sys_bus_pkg::SEL_W; b++) begin
        if (req.sel[b]) gpio_out[8*b +: 8] <= req.wdt[8*b +: 8];
      end
    end
  end

  // two flops, 2 cycles to IN
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      in_meta <= '0;
      in_sync <= '0;
    end else begin
      in_meta <= gpio_in;
      in_sync <= in_meta;
    end
  end

  // registered read mux
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rdt_q <= '0;
    end else if (rd) begin
      rdt_q <= sel_in ? in_sync : gpio_out;
    end
  end

  // writes to IN are dropped, ack is unconditional
  assign rsp = '{rdt: rdt_q, ack: 1'b1};

endmodule

//--- hw/sys_txq.sv
////////////////////////////////////////////////////////////
// transmit queue, bus writes to DATA become a valid/ready
// byte stream, STAT reads the fill level and full flag
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_txq #(
  parameter int unsigned TXQ_DEPTH = 4  // power of two, 2 or more
) (
  input  logic                  clk,
  input  logic                  rst,
  input  sys_bus_pkg::sys_req_t req,
  output sys_bus_pkg::sys_rsp_t rsp,
  output logic [7:0]            tx_data,
  output logic                  tx_valid,
  input  logic                  tx_ready
);

  localparam int unsigned PTR_W = $clog2(TXQ_DEPTH);
  localparam int unsigned LVL_W = PTR_W + 1;

  logic [7:0]                    fifo [TXQ_DEPTH];
  logic [PTR_W-1:0]              wr_ptr;
  logic [PTR_W-1:0]              rd_ptr;
  logic [LVL_W-1:0]              level;
  logic                          full;
  logic                          is_data;  // DATA vs STAT
  logic                          push;
  logic                          pop;
  logic [sys_bus_pkg::DAT_W-1:0] stat;
  logic [sys_bus_pkg::DAT_W-1:0] rdt_q;

  assign is_data = (req.adr[2] == sys_bus_pkg::TXQ_DATA_OFS[2]);
  assign full    = (level == LVL_W'(TXQ_DEPTH));

  // hold off DATA writes while full, master keeps req up
  assign rsp.ack = ~(req.wen & is_data & full);
  assign rsp.rdt = rdt_q;

  assign push = req.req & req.wen & is_data & ~full;
  assign pop  = tx_valid & tx_ready;

  ////////////////////////////////////////////////////////////
  // FIFO
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) fifo[wr_ptr] <= req.wdt[7:0];  // low byte only
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + PTR_W'(1);
      if (pop)  rd_ptr <= rd_ptr + PTR_W'(1);
      level <= level + LVL_W'(push) - LVL_W'(pop);  // push and pop may coincide
    end
  end

  assign tx_valid = (level != '0);
  assign tx_data  = fifo[rd_ptr];

  // STAT word, level in 7:0, full at 8
  always_comb begin
    stat      = '0;
    stat[7:0] = 8'(level);
    stat[8]   = full;
  end

  // DATA reads return zero, STAT writes ignored
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rdt_q <= '0;
    end else if (req.req & ~req.wen) begin
      rdt_q <= is_data ? '0 : stat;
    end
  end

endmodule

//--- hw/sys_bus_top.sv
////////////////////////////////////////////////////////////
// system bus subsystem top, decoder plus RAM, GPIO and
// transmit queue, device sizes set here
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_bus_top #(
  parameter int unsigned RAM_DEPTH = 256,  // RAM words
  parameter int unsigned TXQ_DEPTH = 4     // queue entries
) (
  input  logic                          clk,
  input  logic                          rst,
  input  sys_bus_pkg::sys_req_t         bus_req,
  output sys_bus_pkg::sys_rsp_t         bus_rsp,
  input  logic [sys_bus_pkg::DAT_W-1:0] gpio_in,
  output logic [sys_bus_pkg::DAT_W-1:0] gpio_out,
  output logic [7:0]                    tx_data,
  output logic                          tx_valid,
  input  logic                          tx_ready
);

  // per-device request and response
  sys_bus_pkg::sys_req_t ram_req,  gpio_req,  txq_req;
  sys_bus_pkg::sys_rsp_t ram_rsp,  gpio_rsp,  txq_rsp;

  sys_bus_dec sys_bus_dec_i (
    .clk      (clk),
    .rst      (rst),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .ram_req  (ram_req),
    .gpio_req (gpio_req),
    .txq_req  (txq_req),
    .ram_rsp  (ram_rsp),
    .gpio_rsp (gpio_rsp),
    .txq_rsp  (txq_rsp)
  );

  sys_ram #(.RAM_DEPTH(RAM_DEPTH)) sys_ram_i (
    .clk (clk),
    .rst (rst),
    .req (ram_req),
    .rsp (ram_rsp)
  );

  sys_gpio sys_gpio_i (
    .clk      (clk),
    .rst      (rst),
    .req      (gpio_req),
    .rsp      (gpio_rsp),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out)
  );

  sys_txq #(.TXQ_DEPTH(TXQ_DEPTH)) sys_txq_i (
    .clk      (clk),
    .rst      (rst),
    .req      (txq_req),
    .rsp      (txq_rsp),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready)
  );

endmodule

//--- verification/sys_bus_chk.sv
////////////////////////////////////////////////////////////
// bus checker with a reference model of RAM, GPIO and TXQ,
// compares acks, read data, gpio_out and the tx stream
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_bus_chk #(
  parameter int unsigned RAM_DEPTH = 256,
  parameter int unsigned TXQ_DEPTH = 4
) (
  input logic                          clk,
  input logic                          rst,
  input sys_bus_pkg::sys_req_t         bus_req,
  input sys_bus_pkg::sys_rsp_t         bus_rsp,
  input logic [sys_bus_pkg::DAT_W-1:0] gpio_in,
  input logic [sys_bus_pkg::DAT_W-1:0] gpio_out,
  input logic [7:0]                    tx_data,
  input logic                          tx_valid,
  input logic                          tx_ready
);

  int          err_cnt = 0;
  logic [31:0] ram_m [RAM_DEPTH];
  logic [3:0]  ram_k [RAM_DEPTH];  // lanes written so far
  logic [31:0] out_m;              // gpio_out model
  logic [31:0] in_s1;              // input sync, stage 1
  logic [31:0] in_s2;              // input sync, IN value
  logic [7:0]  txq_m [$];          // queue contents, oldest first
  bit          rd_pend;            // read data due this cycle
  logic [31:0] rd_exp;
  logic [31:0] rd_msk;             // lanes that are known

  initial begin
    for (int i = 0; i < RAM_DEPTH; i++) begin
      ram_k[i] = '0;
    end
  end

  // byte selects to a bit mask
  function automatic logic [31:0] lane_mask(input logic [3:0] k);
    return {{8{k[3]}}, {8{k[2]}}, {8{k[1]}}, {8{k[0]}}};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    err_cnt++;
  endtask

  ////////////////////////////////////////////////////////////
  // per-cycle compare, all values from before the edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : watch
    int unsigned idx;
    bit          exp_ack;
    bit          pop;
    bit          full;
    if (rst) begin
      out_m   = '0;
      in_s1   = '0;
      in_s2   = '0;
      rd_pend = 1'b0;
      txq_m.delete();
    end else begin
      if (rd_pend && (bus_rsp.rdt & rd_msk) !== (rd_exp & rd_msk)) begin
        report_mismatch("bus_rsp.rdt", rd_exp, bus_rsp.rdt);
      end
      if (gpio_out !== out_m) begin
        report_mismatch("gpio_out", out_m, gpio_out);
      end
      if (tx_valid !== (txq_m.size() != 0)) begin
        report_mismatch("tx_valid", 32'(txq_m.size() != 0), 32'(tx_valid));
      end
      full = (txq_m.size() == TXQ_DEPTH);
      pop  = tx_valid && tx_ready && txq_m.size() != 0;
      if (tx_valid && tx_ready && txq_m.size() == 0) begin
        $display("ERROR at %0t: a byte left the tx stream with nothing queued", $time);
        err_cnt++;
      end else if (pop && tx_data !== txq_m[0]) begin
        report_mismatch("tx_data", 32'(txq_m[0]), 32'(tx_data));
      end
      // only a full queue may hold off a DATA write
      exp_ack = !(bus_req.adr[31:28] == 4'h2 && bus_req.wen && !bus_req.adr[2] && full);
      if (bus_req.req && bus_rsp.ack !== exp_ack) begin
        report_mismatch("bus_rsp.ack", 32'(exp_ack), 32'(bus_rsp.ack));
      end
      rd_pend = bus_req.req && bus_rsp.ack && !bus_req.wen;
      rd_exp  = '0;  // unmapped and DATA reads
      rd_msk  = '1;
      if (bus_req.req && bus_rsp.ack) begin
        case (bus_req.adr[31:28])
          4'h0: begin
            idx = (bus_req.adr >> 2) % RAM_DEPTH;  // word index wraps
            if (bus_req.wen) begin
              for (int b = 0; b < 4; b++) begin
                if (bus_req.sel[b]) begin
                  ram_m[idx][8*b +: 8] = bus_req.wdt[8*b +: 8];
                  ram_k[idx][b]        = 1'b1;
                end
              end
            end else begin
              rd_exp = ram_m[idx];
              rd_msk = lane_mask(ram_k[idx]);
            end
          end
          4'h1: begin
            if (!bus_req.wen) begin
              rd_exp = bus_req.adr[2] ? in_s2 : out_m;
            end else if (!bus_req.adr[2]) begin
              out_m = (out_m & ~lane_mask(bus_req.sel)) | (bus_req.wdt & lane_mask(bus_req.sel));
            end
          end
          4'h2: begin
            if (!bus_req.wen && bus_req.adr[2]) begin
              rd_exp = {23'b0, full, 8'(txq_m.size())};  // STAT
            end else if (bus_req.wen && !bus_req.adr[2]) begin
              txq_m.push_back(bus_req.wdt[7:0]);
            end
          end
          default: ;  // unmapped, no state
        endcase
      end
      if (pop) begin
        void'(txq_m.pop_front());
      end
      in_s2 = in_s1;
      in_s1 = gpio_in;
    end
  end

endmodule

//--- verification/sys_bus_tb.sv
////////////////////////////////////////////////////////////
// testbench top that drives seeded random bus traffic per
// test and leaves the comparing to sys_bus_chk
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_bus_tb;

  localparam int unsigned RAM_DEPTH = 256;
  localparam int unsigned TXQ_DEPTH = 4;
  // cycles per test for ram gpio txq back-pressure unmapped mixed
  localparam int unsigned RUN_LEN   = 400 + 100 + 150 + 40 + 60 + 120;
  localparam int unsigned MAX_CYC   = RUN_LEN * 4;

  localparam logic [31:0] GPIO_OUT = sys_bus_pkg::GPIO_BASE + sys_bus_pkg::GPIO_OUT_OFS;
  localparam logic [31:0] GPIO_IN  = sys_bus_pkg::GPIO_BASE + sys_bus_pkg::GPIO_IN_OFS;
  localparam logic [31:0] TXQ_DATA = sys_bus_pkg::TXQ_BASE + sys_bus_pkg::TXQ_DATA_OFS;
  localparam logic [31:0] TXQ_STAT = sys_bus_pkg::TXQ_BASE + sys_bus_pkg::TXQ_STAT_OFS;

  logic                  clk;
  logic                  rst;
  sys_bus_pkg::sys_req_t bus_req;
  sys_bus_pkg::sys_rsp_t bus_rsp;
  logic [31:0]           gpio_in;
  logic [31:0]           gpio_out;
  logic [7:0]            tx_data;
  logic                  tx_valid;
  logic                  tx_ready;

  integer      seed = 32'h43d6;
  bit          rdy_rand;  // random tx_ready each cycle
  bit          rdy_nxt;   // tx_ready for the next rising edge
  int          pass_cnt;
  int          fail_cnt;
  int          err_base;  // checker errors before this test
  int unsigned cyc;

  sys_bus_top #(.RAM_DEPTH(RAM_DEPTH), .TXQ_DEPTH(TXQ_DEPTH)) sys_bus_top_i (
    .clk      (clk),
    .rst      (rst),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready)
  );

  sys_bus_chk #(.RAM_DEPTH(RAM_DEPTH), .TXQ_DEPTH(TXQ_DEPTH)) chk_i (
    .clk      (clk),
    .rst      (rst),
    .bus_req  (bus_req),
    .bus_rsp  (bus_rsp),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    return rand_word() % n;
  endfunction

  // 16 words with half of them through the alias above RAM_DEPTH
  function automatic logic [31:0] ram_adr();
    return (pick(16) + ((pick(2) == 0) ? RAM_DEPTH : 0)) << 2;
  endfunction

  function automatic logic [31:0] none_adr();
    return {4'(3 + pick(13)), 28'(rand_word())};  // bits 31:28 of 3..15
  endfunction

  // next tx_ready value drawn on the falling edge
  always @(negedge clk) begin
    if (rdy_rand) rdy_nxt = 1'(pick(2));
  end

  always @(posedge clk) begin
    if (rdy_rand) tx_ready <= rdy_nxt;
  end

  ////////////////////////////////////////////////////////////
  // bus tasks called and returning on a rising edge
  ////////////////////////////////////////////////////////////

  task automatic access(input bit wen, input logic [31:0] adr, input logic [3:0] sel,
                        input logic [31:0] wdt);
    bus_req <= '{req: 1'b1, wen: wen, adr: adr, sel: sel, wdt: wdt};
    @(negedge clk);
    while (!bus_rsp.ack) @(negedge clk);  // held until ack
    @(posedge clk);                       // transfer edge
  endtask

  task automatic idle(input int n);
    bus_req.req <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic drain_tx();
    idle(1);
    do @(negedge clk); while (tx_valid);
    @(posedge clk);
  endtask

  task automatic finish_test(input string name);
    idle(3);         // last read data compared
    @(negedge clk);  // checker counts settled between edges
    if (chk_i.err_cnt == err_base) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, chk_i.err_cnt - err_base);
    end
    err_base = chk_i.err_cnt;
    @(posedge clk);
  endtask

  initial begin
    cyc = 0;
    while (cyc < MAX_CYC) begin
      @(posedge clk);
      cyc++;
    end
    $display("timeout: tests still running after %0d cycles", MAX_CYC);
    $display("Simulation FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst      = 1'b1;
    bus_req  = '0;
    gpio_in  = '0;
    tx_ready = 1'b0;
    rdy_rand = 1'b0;
    pass_cnt = 0;
    fail_cnt = 0;
    err_base = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    rdy_rand <= 1'b1;

    for (int i = 0; i < 200; i++) begin
      access(1'b1, ram_adr(), 4'(pick(16)), rand_word());
      if (pick(2) == 0) access(1'b0, ram_adr(), 4'hf, 32'h0);
    end
    finish_test("ram");

    for (int i = 0; i < 20; i++) begin
      access(1'b1, GPIO_OUT, 4'(pick(16)), rand_word());
      access(1'b0, GPIO_OUT, 4'hf, 32'h0);
    end
    for (int i = 0; i < 8; i++) begin
      gpio_in <= rand_word();
      idle(3);  // past the synchronizer
      access(1'b0, GPIO_IN, 4'hf, 32'h0);
    end
    finish_test("gpio");

    for (int i = 0; i < 50; i++) begin
      access(1'b1, TXQ_DATA, 4'h1, rand_word());
      if (pick(3) == 0) access(1'b0, TXQ_STAT, 4'hf, 32'h0);
    end
    drain_tx();
    finish_test("txq");

    rdy_rand <= 1'b0;
    @(posedge clk);
    tx_ready <= 1'b0;
    for (int i = 0; i < TXQ_DEPTH; i++) begin
      access(1'b1, TXQ_DATA, 4'h1, rand_word());
    end
    access(1'b0, TXQ_STAT, 4'hf, 32'h0);  // full flag set
    fork
      access(1'b1, TXQ_DATA, 4'h1, rand_word());
      begin
        repeat (6) @(posedge clk);  // write waits meanwhile
        tx_ready <= 1'b1;
      end
    join
    drain_tx();
    rdy_rand <= 1'b1;
    finish_test("back-pressure");

    for (int i = 0; i < 20; i++) begin
      access(1'b1, none_adr(), 4'hf, rand_word());
      access(1'b0, none_adr(), 4'hf, 32'h0);
    end
    for (int i = 0; i < 16; i++) begin
      access(1'b0, 32'(i) << 2, 4'hf, 32'h0);  // RAM untouched
    end
    access(1'b0, GPIO_OUT, 4'hf, 32'h0);
    finish_test("unmapped");

    // no idle cycles so the next request overlaps the read data
    for (int i = 0; i < 100; i++) begin
      case (pick(3))
        0:       access(1'b0, ram_adr(), 4'hf, 32'h0);
        1:       access(1'b0, (pick(2) == 0) ? GPIO_OUT : GPIO_IN, 4'hf, 32'h0);
        default: access(1'b0, none_adr(), 4'hf, 32'h0);
      endcase
    end
    finish_test("mixed");

    @(negedge clk);
    $display("tests passed %0d failed %0d, checker errors %0d",
             pass_cnt, fail_cnt, chk_i.err_cnt);
    if (fail_cnt == 0 && chk_i.err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- sys_bus.f
hw/sys_bus_pkg.sv
hw/sys_bus_dec.sv
hw/sys_ram.sv
hw/sys_gpio.sv
hw/sys_txq.sv
hw/sys_bus_top.sv
verification/sys_bus_chk.sv
verification/sys_bus_tb.sv

//--- Makefile
TOP = sys_bus_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f sys_bus.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -f sys_bus.f --top-module sys_bus_top

clean:
	rm -rf obj_dir sim.log
